// ==== rtl/frame_pkg.sv ====
package frame_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [6:0] count_t;       // 0 to 64 inclusive

    localparam byte_t SOF_BYTE       = 8'hA5;
    localparam int    MAX_DATA_BYTES = 64;

    // Result codes reported with frame_valid or frame_error
    typedef enum logic [7:0] {
        ST_OK      = 8'h00,
        ST_CRC_ERR = 8'h01,
        ST_CMD_INV = 8'h02,
        ST_TIMEOUT = 8'h04
    } status_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2,
        SZ_RSVD = 2'd3                 // Rejected as invalid command
    } size_e;

    // Command byte, bit 7 down to bit 0
    typedef struct packed {
        logic       rw;                // 1 = read, no data bytes
        logic       inc;
        size_e      size;
        logic [3:0] len;               // Beats minus one
    } cmd_t;

    typedef struct packed {
        cmd_t        cmd;
        logic [31:0] addr;             // Little-endian on the wire
    } frame_hdr_t;

    // Head of the RX FIFO
    typedef struct packed {
        byte_t data;
        logic  empty;
    } rx_byte_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CMD,
        ST_ADDR0,
        ST_ADDR1,
        ST_ADDR2,
        ST_ADDR3,
        ST_DATA,
        ST_CRC,
        ST_DONE,
        ST_ERROR
    } parser_state_e;

endpackage

// ==== rtl/crc8_calc.sv ====
`timescale 1ns/1ps

module crc8_calc
    import frame_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  clear,
    input  logic  en,
    input  byte_t data,
    output byte_t crc
);

    localparam byte_t CRC_POLY = 8'h07;

    byte_t crc_q;

    // One byte through the MSB-first shift register, no reflection
    function automatic byte_t crc8_step(input byte_t crc_in, input byte_t data_in);
        byte_t c;
        c = crc_in ^ data_in;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = {c[6:0], 1'b0} ^ CRC_POLY;
            end else begin
                c = {c[6:0], 1'b0};
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc_q <= '0;                // Initial value 00h
        end else if (en) begin
            crc_q <= crc8_step(crc_q, data);
        end
    end

    assign crc = crc_q;

    // Clear is issued on SOF only, never together with a folded byte
    a_clear_en_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(clear && en));

endmodule

// ==== rtl/idle_timer.sv ====
`timescale 1ns/1ps

module idle_timer
    import frame_pkg::*;
#(
    parameter int CLK_FREQ_HZ        = 125_000_000,
    parameter int BAUD_RATE          = 115_200,
    parameter int TIMEOUT_BYTE_TIMES = 10
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     active,
    input  rx_byte_t rx,
    output logic     timed_out
);

    // Ten bit times per UART character
    localparam int BYTE_TIME_CLOCKS = CLK_FREQ_HZ / (BAUD_RATE / 10);
    localparam int TIMEOUT_CLOCKS   = BYTE_TIME_CLOCKS * TIMEOUT_BYTE_TIMES;
    localparam int CNT_W            = $clog2(TIMEOUT_CLOCKS + 1);

    logic [CNT_W-1:0] idle_cnt;
    logic             cnt_sat;

    assign cnt_sat = (idle_cnt == CNT_W'(TIMEOUT_CLOCKS));

    always_ff @(posedge clk) begin
        if (rst || !active || !rx.empty) begin
            idle_cnt <= '0;             // Any byte restarts the window
        end else if (!cnt_sat) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // Held until a byte shows up or the frame ends
    assign timed_out = cnt_sat;

endmodule

// ==== rtl/frame_data_buffer.sv ====
`timescale 1ns/1ps

module frame_data_buffer
    import frame_pkg::*;
(
    input  logic   clk,
    input  logic   wr_en,
    input  count_t wr_idx,
    input  byte_t  wr_byte,
    input  count_t rd_idx,
    output byte_t  rd_byte
);

    localparam int IDX_W = $clog2(MAX_DATA_BYTES);

    byte_t mem [MAX_DATA_BYTES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx[IDX_W-1:0]] <= wr_byte;
        end
    end

    // Same-cycle read, zero beyond the buffer depth
    always_comb begin
        if (rd_idx < count_t'(MAX_DATA_BYTES)) begin
            rd_byte = mem[rd_idx[IDX_W-1:0]];
        end else begin
            rd_byte = '0;
        end
    end

    // Expected count from the command never exceeds the depth
    a_wr_idx_range: assert property (@(posedge clk)
        wr_en |-> (wr_idx < count_t'(MAX_DATA_BYTES)));

endmodule

// ==== rtl/frame_fsm.sv ====
`timescale 1ns/1ps

module frame_fsm
    import frame_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  rx_byte_t   rx,
    output logic       rx_rd_en,

    output logic       crc_clear,
    output logic       crc_en,
    input  byte_t      crc_value,

    output logic       timer_active,
    input  logic       timed_out,

    output logic       buf_wr_en,
    output count_t     buf_wr_idx,

    output frame_hdr_t frame_hdr,
    output count_t     data_count,
    output status_e    status,
    output logic       frame_valid,
    output logic       frame_error,
    input  logic       frame_consumed
);

    parser_state_e state, state_next;

    frame_hdr_t hdr_q;
    count_t     exp_count;              // Data bytes announced by the command
    count_t     data_cnt;
    count_t     data_cnt_inc;
    status_e    status_q;
    logic       byte_avail;

    // Reads carry no data; size 3 also carries none and is flagged later
    function automatic count_t data_bytes_for(input cmd_t c);
        count_t beats;
        beats = count_t'(c.len) + count_t'(1);
        if (c.rw) begin
            return '0;
        end
        case (c.size)
            SZ_BYTE: return beats;
            SZ_HALF: return beats << 1;
            SZ_WORD: return beats << 2;
            default: return '0;
        endcase
    endfunction

    assign byte_avail   = !rx.empty;
    assign data_cnt_inc = data_cnt + count_t'(1);

    always_comb begin
        state_next   = state;
        rx_rd_en     = 1'b0;
        crc_clear    = 1'b0;
        crc_en       = 1'b0;
        timer_active = 1'b0;
        buf_wr_en    = 1'b0;

        unique case (state)
            ST_IDLE: begin
                if (byte_avail) begin
                    rx_rd_en = 1'b1;     // Non-SOF bytes are dropped here
                    if (rx.data == SOF_BYTE) begin
                        crc_clear  = 1'b1;
                        state_next = ST_CMD;
                    end
                end
            end
            ST_CMD, ST_ADDR0, ST_ADDR1, ST_ADDR2, ST_ADDR3, ST_DATA: begin
                timer_active = 1'b1;
                if (byte_avail) begin
                    rx_rd_en = 1'b1;
                    crc_en   = 1'b1;
                    if (state == ST_ADDR3) begin
                        state_next = (exp_count == '0) ? ST_CRC : ST_DATA;
                    end else if (state == ST_DATA) begin
                        buf_wr_en = 1'b1;
                        if (data_cnt_inc == exp_count) begin
                            state_next = ST_CRC;
                        end
                    end else begin
                        state_next = parser_state_e'(state + 1'b1); // Next header field
                    end
                end else if (timed_out) begin
                    state_next = ST_ERROR;
                end
            end
            ST_CRC: begin
                timer_active = 1'b1;
                if (byte_avail) begin
                    rx_rd_en   = 1'b1;
                    state_next = ST_DONE;
                end else if (timed_out) begin
                    state_next = ST_ERROR;
                end
            end
            ST_DONE, ST_ERROR: begin
                if (frame_consumed) begin
                    state_next = ST_IDLE;   // FIFO stays untouched while held
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            status_q  <= ST_OK;
            exp_count <= '0;
            data_cnt  <= '0;
        end else begin
            state <= state_next;
            if (crc_clear) begin
                status_q <= ST_OK;
                data_cnt <= '0;
            end
            if (state == ST_CMD && byte_avail) begin
                exp_count <= data_bytes_for(cmd_t'(rx.data));
            end
            if (buf_wr_en) begin
                data_cnt <= data_cnt_inc;
            end
            if (state_next == ST_ERROR && state != ST_ERROR) begin
                status_q <= ST_TIMEOUT;
            end
            // Result is final on the CRC byte itself
            if (state == ST_CRC && byte_avail) begin
                if (hdr_q.cmd.size == SZ_RSVD) begin
                    status_q <= ST_CMD_INV;
                end else if (rx.data != crc_value) begin
                    status_q <= ST_CRC_ERR;
                end else begin
                    status_q <= ST_OK;
                end
            end
        end
    end

    // Header fields are only meaningful while a result is held
    always_ff @(posedge clk) begin
        if (byte_avail) begin
            case (state)
                ST_CMD:   hdr_q.cmd          <= cmd_t'(rx.data);
                ST_ADDR0: hdr_q.addr[7:0]    <= rx.data;
                ST_ADDR1: hdr_q.addr[15:8]   <= rx.data;
                ST_ADDR2: hdr_q.addr[23:16]  <= rx.data;
                ST_ADDR3: hdr_q.addr[31:24]  <= rx.data;
                default: ;
            endcase
        end
    end

    assign buf_wr_idx  = data_cnt;
    assign frame_hdr   = hdr_q;
    assign data_count  = data_cnt;
    assign status      = status_q;
    assign frame_valid = (state == ST_DONE) && (status_q == ST_OK);
    assign frame_error = ((state == ST_DONE) && (status_q != ST_OK)) || (state == ST_ERROR);

    // A held result does not move until the consumer takes it
    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        (frame_valid || frame_error) && !frame_consumed
        |=> $stable(status) && $stable(data_count) && (frame_valid || frame_error));

    // Data phase ends on the announced count so the buffer index stays in range
    a_data_in_range: assert property (@(posedge clk) disable iff (rst)
        (state == ST_DATA) |-> (data_cnt < exp_count));

endmodule

// ==== rtl/frame_parser_top.sv ====
`timescale 1ns/1ps

module frame_parser_top
    import frame_pkg::*;
#(
    parameter int CLK_FREQ_HZ        = 125_000_000,
    parameter int BAUD_RATE          = 115_200,
    parameter int TIMEOUT_BYTE_TIMES = 10
) (
    input  logic       clk,
    input  logic       rst,

    // RX FIFO head
    input  byte_t      rx_data,
    input  logic       rx_empty,
    output logic       rx_rd_en,

    // Parsed result, held until frame_consumed
    output frame_hdr_t frame_hdr,
    output count_t     data_count,
    output status_e    status,
    output logic       frame_valid,
    output logic       frame_error,
    input  logic       frame_consumed,

    input  count_t     data_rd_idx,
    output byte_t      data_rd_byte
);

    rx_byte_t rx_head;
    logic     crc_clear;
    logic     crc_en;
    byte_t    crc_value;
    logic     timer_active;
    logic     timed_out;
    logic     buf_wr_en;
    count_t   buf_wr_idx;

    assign rx_head = '{data: rx_data, empty: rx_empty};

    frame_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx_head),
        .rx_rd_en       (rx_rd_en),
        .crc_clear      (crc_clear),
        .crc_en         (crc_en),
        .crc_value      (crc_value),
        .timer_active   (timer_active),
        .timed_out      (timed_out),
        .buf_wr_en      (buf_wr_en),
        .buf_wr_idx     (buf_wr_idx),
        .frame_hdr      (frame_hdr),
        .data_count     (data_count),
        .status         (status),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .frame_consumed (frame_consumed)
    );

    crc8_calc u_crc (
        .clk   (clk),
        .rst   (rst),
        .clear (crc_clear),
        .en    (crc_en),
        .data  (rx_data),                // Same byte the FSM accepts
        .crc   (crc_value)
    );

    idle_timer #(
        .CLK_FREQ_HZ        (CLK_FREQ_HZ),
        .BAUD_RATE          (BAUD_RATE),
        .TIMEOUT_BYTE_TIMES (TIMEOUT_BYTE_TIMES)
    ) u_timer (
        .clk       (clk),
        .rst       (rst),
        .active    (timer_active),
        .rx        (rx_head),
        .timed_out (timed_out)
    );

    frame_data_buffer u_buf (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_idx  (buf_wr_idx),
        .wr_byte (rx_head.data),
        .rd_idx  (data_rd_idx),
        .rd_byte (data_rd_byte)
    );

endmodule

// ==== verif/tb_frame_parser.sv ====
`timescale 1ns/1ps

module tb_frame_parser
    import frame_pkg::*;
();

    localparam int    HALF_PERIOD   = 5;
    localparam int    RESET_CYCLES  = 5;
    localparam int    TIMEOUT_BOUND = 210;       // Cycles allowed for a stalled frame
    localparam string TRACE_FILE    = "verif/frame_trace.txt";

    logic       clk = 1'b0;
    logic       rst;
    byte_t      rx_data;
    logic       rx_empty;
    logic       rx_rd_en;
    frame_hdr_t frame_hdr;
    count_t     data_count;
    status_e    status;
    logic       frame_valid;
    logic       frame_error;
    logic       frame_consumed;
    count_t     data_rd_idx;
    byte_t      data_rd_byte;

    byte_t fifo_q[$];                            // RX FIFO model with the head at index 0
    byte_t trace_data [MAX_DATA_BYTES];
    int    fd;
    int    errors = 0;
    int    total_bytes = 0;
    int    timeout_tests = 0;
    int    expects_listed = 0;
    int    expects_done = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    logic  limit_armed = 1'b0;

    frame_parser_top #(
        .CLK_FREQ_HZ        (1_000_000),
        .BAUD_RATE          (100_000),
        .TIMEOUT_BYTE_TIMES (2)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .rx_data        (rx_data),
        .rx_empty       (rx_empty),
        .rx_rd_en       (rx_rd_en),
        .frame_hdr      (frame_hdr),
        .data_count     (data_count),
        .status         (status),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .frame_consumed (frame_consumed),
        .data_rd_idx    (data_rd_idx),
        .data_rd_byte   (data_rd_byte)
    );

    always #HALF_PERIOD clk = ~clk;

    // FIFO pops on the edge where the parser reads
    always @(posedge clk) begin
        if (!rst && rx_rd_en && fifo_q.size() > 0) begin
            void'(fifo_q.pop_front());
        end
    end

    // Held result must keep the FIFO untouched
    always @(posedge clk) begin
        if (!rst && (frame_valid || frame_error) && rx_rd_en) begin
            errors++;
            $display("FIFO was read while a result was held");
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (limit_armed && cycle_cnt >= cycle_limit) begin
            $display("Run stopped at the limit of %0d cycles, a result never arrived", cycle_limit);
            $display("Stopped with %0d errors", errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic drive_fifo_head();
        if (fifo_q.size() == 0) begin
            rx_empty = 1'b1;
            rx_data  = 8'h00;
        end else begin
            rx_empty = 1'b0;
            rx_data  = fifo_q[0];
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        drive_fifo_head();
    endtask

    // Bitwise CRC-8 over poly 07h with the message bits taken MSB first
    function automatic byte_t crc_fold(input byte_t crc, input byte_t data);
        byte_t r;
        logic  fb;
        r = crc;
        for (int b = 7; b >= 0; b--) begin
            fb = r[7] ^ data[b];
            r  = {r[6:0], 1'b0};
            if (fb) begin
                r = r ^ 8'h07;
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(input logic [8*16-1:0] test, input string field,
                                   input logic [39:0] expected, input logic [39:0] actual);
        errors++;
        $display("error %0s %0s: expected %0h, actual %0h", test, field, expected, actual);
    endtask

    task automatic check_result(input logic [8*16-1:0] test, input byte_t exp_status,
                                input byte_t exp_cmd, input logic [31:0] exp_addr,
                                input int exp_count);
        int   waited;
        int   held;
        logic want_valid;
        waited = 0;
        while (!(frame_valid || frame_error)) begin
            next_cycle();
            waited++;
        end
        want_valid = (exp_status == ST_OK);
        if (frame_valid !== want_valid) begin
            report_mismatch(test, "frame_valid", 40'(want_valid), 40'(frame_valid));
        end
        if (frame_error !== !want_valid) begin
            report_mismatch(test, "frame_error", 40'(!want_valid), 40'(frame_error));
        end
        if (byte_t'(status) !== exp_status) begin
            report_mismatch(test, "status", 40'(exp_status), 40'(byte_t'(status)));
        end
        if (exp_status == ST_TIMEOUT) begin
            if (waited > TIMEOUT_BOUND) begin
                errors++;
                $display("%0s: timeout came after %0d cycles, beyond the bound of %0d",
                         test, waited, TIMEOUT_BOUND);
            end
        end else begin
            if (byte_t'(frame_hdr.cmd) !== exp_cmd) begin
                report_mismatch(test, "cmd", 40'(exp_cmd), 40'(byte_t'(frame_hdr.cmd)));
            end
            if (frame_hdr.addr !== exp_addr) begin
                report_mismatch(test, "addr", 40'(exp_addr), 40'(frame_hdr.addr));
            end
        end
        if (data_count !== count_t'(exp_count)) begin
            report_mismatch(test, "data_count", 40'(exp_count), 40'(data_count));
        end
        held = fifo_q.size();
        for (int i = 0; i < exp_count; i++) begin
            data_rd_idx = count_t'(i);
            next_cycle();
            if (data_rd_byte !== trace_data[i]) begin
                report_mismatch(test, "data byte", 40'(trace_data[i]), 40'(data_rd_byte));
            end
        end
        if (fifo_q.size() != held) begin
            errors++;
            $display("%0s: bytes left the FIFO while the result was held", test);
        end
        frame_consumed = 1'b1;
        next_cycle();
        frame_consumed = 1'b0;
        data_rd_idx    = '0;
        if (frame_valid || frame_error) begin
            errors++;
            $display("%0s: result still held one cycle after frame_consumed", test);
        end
        expects_done++;
    endtask

    // Dry pass only counts and checks the listed CRCs
    task automatic process_trace(input logic dry);
        logic [7:0]       key;
        logic [8*16-1:0]  test;
        logic [8*128-1:0] rest;
        int               rc;
        int               chk;
        int               n;
        byte_t            b;
        byte_t            crc;
        byte_t            exp_status;
        byte_t            exp_cmd;
        logic [31:0]      exp_addr;
        int               exp_count;
        while ($fscanf(fd, "%s", key) == 1) begin
            if (key == "#") begin
                rc = $fgets(rest, fd);
            end else if (key == "W") begin
                rc = $fscanf(fd, "%d", n);
                if (!dry) begin
                    repeat (n) next_cycle();
                end
            end else if (key == "B") begin
                rc  = $fscanf(fd, "%d %d", chk, n);
                crc = '0;
                for (int i = 0; i < n; i++) begin
                    rc = $fscanf(fd, "%h", b);
                    if (dry && i > 0 && i < n - 1) begin
                        crc = crc_fold(crc, b);   // SOF and CRC byte are not covered
                    end
                    if (!dry) begin
                        fifo_q.push_back(b);
                    end
                end
                if (dry) begin
                    total_bytes += n;
                    if (chk != 0 && crc !== b) begin
                        report_mismatch("trace_crc", "crc byte", 40'(crc), 40'(b));
                    end
                end else begin
                    drive_fifo_head();
                end
            end else if (key == "X") begin
                rc = $fscanf(fd, "%s %h %h %h %h", test, exp_status, exp_cmd, exp_addr,
                             exp_count);
                for (int i = 0; i < exp_count; i++) begin
                    rc = $fscanf(fd, "%h", trace_data[i]);
                end
                if (dry) begin
                    expects_listed++;
                    if (exp_status == ST_TIMEOUT) begin
                        timeout_tests++;
                    end
                end else begin
                    check_result(test, exp_status, exp_cmd, exp_addr, exp_count);
                end
            end else begin
                errors++;
                $display("Unknown keyword in the trace file");
            end
        end
    endtask

    initial begin
        rst            = 1'b1;
        rx_data        = 8'h00;
        rx_empty       = 1'b1;
        frame_consumed = 1'b0;
        data_rd_idx    = '0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Trace file %0s could not be opened", TRACE_FILE);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            process_trace(1'b1);
            $fclose(fd);
            cycle_limit = 20 * total_bytes + 400 * timeout_tests + 200;
            limit_armed = 1'b1;
            repeat (RESET_CYCLES) @(negedge clk);
            rst = 1'b0;
            fd  = $fopen(TRACE_FILE, "r");
            process_trace(1'b0);
            $fclose(fd);
            if (expects_done != expects_listed) begin
                errors++;
                $display("Only %0d of %0d listed results were checked", expects_done,
                         expects_listed);
            end
            $display("Checks finished with %0d errors", errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== verif/frame_trace.txt ====
# B chk n byte... : push n hex bytes, chk 1 means SOF frame whose last byte is a good CRC
# W n : wait n cycles   X name status cmd addr count data... : expected result, all hex
W 3
B 1 15 A5 61 78 56 34 12 01 02 03 04 05 06 07 08 37
X word_write 00 61 12345678 8 01 02 03 04 05 06 07 08
B 1 7 A5 80 00 10 00 00 35
X read_addr 00 80 00001000 0
B 0 8 A5 40 C0 00 00 00 5A A9
X bad_crc 01 40 000000C0 1 5A
B 1 7 A5 30 20 00 00 00 98
X bad_size 02 30 00000020 0
B 0 3 00 5A 13
B 1 8 A5 40 C0 00 00 00 5A A8
B 1 7 A5 80 00 10 00 00 35
W 2
X after_garbage 00 40 000000C0 1 5A
X queued_read 00 80 00001000 0
B 0 4 A5 61 11 22
X stall_timeout 04 61 00002211 0
B 1 8 A5 40 C0 00 00 00 5A A8
X after_timeout 00 40 000000C0 1 5A

// ==== frame_parser_top.f ====
rtl/frame_pkg.sv
rtl/crc8_calc.sv
rtl/idle_timer.sv
rtl/frame_data_buffer.sv
rtl/frame_fsm.sv
rtl/frame_parser_top.sv
verif/tb_frame_parser.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame parser testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_frame_parser \
    -f frame_parser_top.f

output=$(./obj_dir/Vtb_frame_parser)
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1
